//--- cpu_isa_pkg.sv
package cpu_isa_pkg;

    // issued operation, 4 bits wide
    typedef enum logic [3:0] {
        op_add     = 4'd0,
        op_sub     = 4'd1,
        op_and     = 4'd2,
        op_or      = 4'd3,
        op_xor     = 4'd4,
        op_slt     = 4'd5,
        op_mtc0    = 4'd6,
        op_mfc0    = 4'd7,
        op_eret    = 4'd8,
        op_syscall = 4'd9
    } op_e;

    // cause excode values
    typedef enum logic [4:0] {
        exc_int = 5'd0,  // interrupt
        exc_sys = 5'd8,  // syscall
        exc_ov  = 5'd12  // integer overflow
    } exc_e;

    // cp0 register numbers, sel 0 only
    typedef enum logic [4:0] {
        cp0_status = 5'd12,
        cp0_cause  = 5'd13,
        cp0_epc    = 5'd14
    } cp0_reg_e;

    localparam logic [31:0] exc_vector = 32'hbfc0_0380;  // bev=1 general vector

    // status bit positions
    localparam int status_bev = 22;  // hardwired to 1
    localparam int status_exl = 1;
    localparam int status_ie  = 0;

    // cause bit positions
    localparam int cause_bd    = 31;
    localparam int exccode_lsb = 2;  // excode lives in [6:2]

    // im in status and ip in cause share the same [15:8] slot
    localparam int int_field_lsb = 8;

    // epc of an op in a delay slot points back at the branch
    localparam logic [31:0] delay_slot_back = 32'd4;

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

    import cpu_isa_pkg::*;

    // issue -> ex
    typedef struct packed {
        op_e         op;
        logic [31:0] pc;
        logic [31:0] src_a;   // rs value, also mtc0 write data
        logic [31:0] src_b;   // rt value
        logic [4:0]  dest;    // gpr destination
        cp0_reg_e    cp0_rd;  // cp0 register for mtc0/mfc0
        logic        bd;      // op sits in a branch delay slot
    } ex_bus_t;

    // ex -> m1
    typedef struct packed {
        op_e         op;
        logic [31:0] pc;
        logic [31:0] result;  // alu result or mtc0 data
        logic [4:0]  dest;
        logic        we;      // gpr write enable
        cp0_reg_e    cp0_rd;
        logic        bd;
        logic        ex;      // exception detected in ex
        exc_e        exccode;
    } m1_bus_t;

    // m1 -> wb
    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  dest;
        logic [31:0] data;    // final write-back value
        logic        ex;
        exc_e        exccode;
    } wb_bus_t;

endpackage

//--- stage_if.sv
// one pipeline boundary, valid/allowin handshake
interface stage_if #(
    parameter type bus_t = logic
);

    logic valid;    // producer has an op
    logic allowin;  // consumer can take it
    bus_t bus;      // payload, stable while allowin low

    // upstream side
    modport src (
        output valid,
        output bus,
        input  allowin
    );

    // downstream side
    modport dst (
        input  valid,
        input  bus,
        output allowin
    );

endinterface

//--- ex_stage.sv
module ex_stage
    import cpu_isa_pkg::*, pipe_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    issue_valid,
    output logic    issue_allowin,
    input  ex_bus_t issue_bus,
    input  logic    flush,      // from m1, kills the op held here
    stage_if.src    m1
);

    logic        ex_valid;
    ex_bus_t     ex_r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sum;
    logic [31:0] diff;
    logic [31:0] alu_res;
    logic        ovf;
    logic        is_alu;
    logic        is_sys;
    logic        exc;
    m1_bus_t     out_bus;

    // no new op accepted while m1 redirects
    assign issue_allowin = !flush && (!ex_valid || m1.allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;  // younger op dropped
        end else if (issue_allowin) begin
            ex_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_allowin) begin
            ex_r <= issue_bus;
        end
    end

    assign a    = ex_r.src_a;
    assign b    = ex_r.src_b;
    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        alu_res = 32'd0;
        ovf     = 1'b0;
        is_alu  = 1'b1;
        case (ex_r.op)
            op_add: begin
                alu_res = sum;
                ovf     = (a[31] == b[31]) && (sum[31] != a[31]);  // same signs in, flip out
            end
            op_sub: begin
                alu_res = diff;
                ovf     = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            op_and:  alu_res = a & b;
            op_or:   alu_res = a | b;
            op_xor:  alu_res = a ^ b;
            op_slt:  alu_res = {31'd0, $signed(a) < $signed(b)};
            op_mtc0: begin
                alu_res = a;  // cp0 write data rides in result
                is_alu  = 1'b0;
            end
            default: is_alu = 1'b0;  // mfc0, eret, syscall
        endcase
    end

    assign is_sys = (ex_r.op == op_syscall);
    assign exc    = ovf || is_sys;

    always_comb begin
        out_bus.op      = ex_r.op;
        out_bus.pc      = ex_r.pc;
        out_bus.result  = alu_res;
        out_bus.dest    = ex_r.dest;
        out_bus.we      = (is_alu || ex_r.op == op_mfc0) && !exc;
        out_bus.cp0_rd  = ex_r.cp0_rd;
        out_bus.bd      = ex_r.bd;
        out_bus.ex      = exc;
        out_bus.exccode = is_sys ? exc_sys : (ovf ? exc_ov : exc_int);  // 0 when clean
    end

    assign m1.valid = ex_valid && !flush;  // flushed op never reaches m1
    assign m1.bus   = out_bus;

endmodule

//--- cp0_regs.sv
module cp0_regs
    import cpu_isa_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [5:0]  ext_int,
    input  logic        access_valid,  // op commits this cycle without exception
    input  op_e         op,
    input  cp0_reg_e    cp0_rd,
    input  logic [31:0] wdata,
    input  logic [31:0] pc,
    input  logic        bd,
    input  logic        take_exc,      // exception entry this cycle
    input  exc_e        exccode,
    output logic [31:0] rdata,
    output logic        int_pending,
    output logic [31:0] epc
);

    // status fields
    logic [7:0]  status_im;
    logic        status_exl_r;
    logic        status_ie_r;

    // cause fields
    logic        cause_bd_r;
    logic [5:0]  cause_ip_hw;  // ip[7:2], follows ext_int
    logic [1:0]  cause_ip_sw;  // ip[1:0], software set
    exc_e        cause_exccode;

    logic [7:0]  cause_ip;
    logic [31:0] status_word;
    logic [31:0] cause_word;
    logic        do_mtc0;
    logic        do_eret;

    assign cause_ip = {cause_ip_hw, cause_ip_sw};
    assign do_mtc0  = access_valid && (op == op_mtc0);
    assign do_eret  = access_valid && (op == op_eret);

    // masked and enabled, not inside a handler
    assign int_pending = status_ie_r && !status_exl_r && |(cause_ip & status_im);

    // hardware ip lines sampled every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_ip_hw <= 6'd0;
        end else begin
            cause_ip_hw <= ext_int;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status_im     <= 8'd0;
            status_exl_r  <= 1'b0;
            status_ie_r   <= 1'b0;
            cause_bd_r    <= 1'b0;
            cause_ip_sw   <= 2'd0;
            cause_exccode <= exc_int;
            epc           <= 32'd0;
        end else if (take_exc) begin
            status_exl_r  <= 1'b1;
            cause_bd_r    <= bd;
            cause_exccode <= exccode;
            epc           <= bd ? pc - delay_slot_back : pc;  // restart at the branch
        end else if (do_eret) begin
            status_exl_r <= 1'b0;
        end else if (do_mtc0) begin
            case (cp0_rd)
                cp0_status: begin
                    status_im    <= wdata[int_field_lsb +: 8];
                    status_exl_r <= wdata[status_exl];
                    status_ie_r  <= wdata[status_ie];
                end
                cp0_cause: cause_ip_sw <= wdata[int_field_lsb +: 2];  // only sw ip writable
                cp0_epc:   epc         <= wdata;
                default: ;
            endcase
        end
    end

    // read views, unimplemented bits zero
    always_comb begin
        status_word                       = 32'd0;
        status_word[status_bev]           = 1'b1;
        status_word[int_field_lsb +: 8]   = status_im;
        status_word[status_exl]           = status_exl_r;
        status_word[status_ie]            = status_ie_r;
    end

    always_comb begin
        cause_word                        = 32'd0;
        cause_word[cause_bd]              = cause_bd_r;
        cause_word[int_field_lsb +: 8]    = cause_ip;
        cause_word[exccode_lsb +: 5]      = cause_exccode;
    end

    always_comb begin
        case (cp0_rd)
            cp0_status: rdata = status_word;
            cp0_cause:  rdata = cause_word;
            cp0_epc:    rdata = epc;
            default:    rdata = 32'd0;
        endcase
    end

endmodule

//--- m1_stage.sv
module m1_stage
    import cpu_isa_pkg::*, pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [5:0]  ext_int,
    stage_if.dst        ex,
    stage_if.src        wb,
    output logic        flush,
    output logic [31:0] flush_target
);

    logic        m1_valid;
    m1_bus_t     m1_r;
    logic        transfer;
    logic        int_pending;
    logic        final_ex;
    exc_e        final_code;
    logic        is_eret;
    logic [31:0] cp0_rdata;
    logic [31:0] cp0_epc_val;
    wb_bus_t     out_bus;

    assign ex.allowin = !m1_valid || wb.allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            m1_valid <= 1'b0;
        end else if (ex.allowin) begin
            m1_valid <= ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.valid && ex.allowin) begin
            m1_r <= ex.bus;
        end
    end

    assign transfer   = m1_valid && wb.allowin;      // commit point
    assign final_ex   = m1_r.ex || int_pending;      // interrupt wins
    assign final_code = int_pending ? exc_int : m1_r.exccode;
    assign is_eret    = (m1_r.op == op_eret) && !final_ex;

    cp0_regs u_cp0_regs (
        .clk          (clk),
        .reset        (reset),
        .ext_int      (ext_int),
        .access_valid (transfer && !final_ex),
        .op           (m1_r.op),
        .cp0_rd       (m1_r.cp0_rd),
        .wdata        (m1_r.result),
        .pc           (m1_r.pc),
        .bd           (m1_r.bd),
        .take_exc     (transfer && final_ex),
        .exccode      (final_code),
        .rdata        (cp0_rdata),
        .int_pending  (int_pending),
        .epc          (cp0_epc_val)
    );

    // redirect rides with the op into wb
    assign flush        = transfer && (final_ex || is_eret);
    assign flush_target = is_eret ? cp0_epc_val : exc_vector;

    always_comb begin
        out_bus.pc      = m1_r.pc;
        out_bus.we      = m1_r.we && !final_ex;  // excepting op writes nothing
        out_bus.dest    = m1_r.dest;
        out_bus.data    = (m1_r.op == op_mfc0) ? cp0_rdata : m1_r.result;
        out_bus.ex      = final_ex;
        out_bus.exccode = final_code;
    end

    assign wb.valid = m1_valid;
    assign wb.bus   = out_bus;

endmodule

//--- wb_stage.sv
module wb_stage
    import cpu_isa_pkg::*, pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    stage_if.dst        m1,
    output logic        retire_valid,
    input  logic        retire_allowin,  // back-pressure from the consumer
    output logic [31:0] retire_pc,
    output logic        retire_we,
    output logic [4:0]  retire_dest,
    output logic [31:0] retire_data,
    output logic        retire_ex,
    output exc_e        retire_exccode
);

    logic    wb_valid;
    wb_bus_t wb_r;

    // last stage, drains only when retire side takes it
    assign m1.allowin = !wb_valid || retire_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else if (m1.allowin) begin
            wb_valid <= m1.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (m1.valid && m1.allowin) begin
            wb_r <= m1.bus;
        end
    end

    // retired op fields, held while stalled
    assign retire_valid   = wb_valid;
    assign retire_pc      = wb_r.pc;
    assign retire_we      = wb_r.we;
    assign retire_dest    = wb_r.dest;
    assign retire_data    = wb_r.data;
    assign retire_ex      = wb_r.ex;
    assign retire_exccode = wb_r.exccode;

endmodule

//--- backend_top.sv
module backend_top
    import cpu_isa_pkg::*, pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [5:0]  ext_int,
    // issue side
    input  logic        issue_valid,
    output logic        issue_allowin,
    input  op_e         issue_op,
    input  logic [31:0] issue_pc,
    input  logic [31:0] issue_src_a,
    input  logic [31:0] issue_src_b,
    input  logic [4:0]  issue_dest,
    input  cp0_reg_e    issue_cp0_rd,
    input  logic        issue_bd,
    // retire side
    output logic        retire_valid,
    input  logic        retire_allowin,
    output logic [31:0] retire_pc,
    output logic        retire_we,
    output logic [4:0]  retire_dest,
    output logic [31:0] retire_data,
    output logic        retire_ex,
    output exc_e        retire_exccode,
    // redirect
    output logic        flush,
    output logic [31:0] flush_target
);

    ex_bus_t issue_bus;

    stage_if #(.bus_t(m1_bus_t)) ex_m1 ();  // ex -> m1
    stage_if #(.bus_t(wb_bus_t)) m1_wb ();  // m1 -> wb

    // pack plain issue ports
    assign issue_bus.op     = issue_op;
    assign issue_bus.pc     = issue_pc;
    assign issue_bus.src_a  = issue_src_a;
    assign issue_bus.src_b  = issue_src_b;
    assign issue_bus.dest   = issue_dest;
    assign issue_bus.cp0_rd = issue_cp0_rd;
    assign issue_bus.bd     = issue_bd;

    ex_stage u_ex_stage (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue_allowin (issue_allowin),
        .issue_bus     (issue_bus),
        .flush         (flush),
        .m1            (ex_m1)
    );

    m1_stage u_m1_stage (
        .clk          (clk),
        .reset        (reset),
        .ext_int      (ext_int),
        .ex           (ex_m1),
        .wb           (m1_wb),
        .flush        (flush),
        .flush_target (flush_target)
    );

    wb_stage u_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .m1             (m1_wb),
        .retire_valid   (retire_valid),
        .retire_allowin (retire_allowin),
        .retire_pc      (retire_pc),
        .retire_we      (retire_we),
        .retire_dest    (retire_dest),
        .retire_data    (retire_data),
        .retire_ex      (retire_ex),
        .retire_exccode (retire_exccode)
    );

endmodule

//--- tb_backend.sv
module tb_backend
    import cpu_isa_pkg::*, pipe_pkg::*;
();

    localparam int     n_ops         = 2000;
    localparam longint watchdog_time = longint'(n_ops) * 20 * 40;  // ops x 20 cycles x period

    // one accepted op as the model tracks it
    typedef struct packed {
        ex_bus_t     ib;
        logic [31:0] acc_cyc;  // cycle of the issue handshake
        logic        flushed;  // flush seen as it left m1
        logic [31:0] tgt;      // flush_target in that cycle
    } entry_t;

    logic        clk = 1'b0;
    logic        reset;
    logic [5:0]  ext_int;
    logic        issue_valid;
    logic        issue_allowin;
    op_e         issue_op;
    logic [31:0] issue_pc;
    logic [31:0] issue_src_a;
    logic [31:0] issue_src_b;
    logic [4:0]  issue_dest;
    cp0_reg_e    issue_cp0_rd;
    logic        issue_bd;
    logic        retire_valid;
    logic        retire_allowin;
    logic [31:0] retire_pc;
    logic        retire_we;
    logic [4:0]  retire_dest;
    logic [31:0] retire_data;
    logic        retire_ex;
    exc_e        retire_exccode;
    logic        flush;
    logic [31:0] flush_target;

    entry_t      q[$];                 // accepted, not yet retired, oldest first
    logic [31:0] cyc;
    logic [31:0] last_stall = 32'd0;   // last cycle with retire_allowin low
    logic        stall_mode = 1'b0;
    int          n_retired  = 0;
    int          n_dropped  = 0;

    // architectural cp0 copy
    logic [7:0]  m_im;
    logic        m_exl;
    logic        m_ie;
    logic        m_bd;
    logic [1:0]  m_ip_sw;
    exc_e        m_code;
    logic [31:0] m_epc;

    backend_top u_backend_top (
        .clk            (clk),
        .reset          (reset),
        .ext_int        (ext_int),
        .issue_valid    (issue_valid),
        .issue_allowin  (issue_allowin),
        .issue_op       (issue_op),
        .issue_pc       (issue_pc),
        .issue_src_a    (issue_src_a),
        .issue_src_b    (issue_src_b),
        .issue_dest     (issue_dest),
        .issue_cp0_rd   (issue_cp0_rd),
        .issue_bd       (issue_bd),
        .retire_valid   (retire_valid),
        .retire_allowin (retire_allowin),
        .retire_pc      (retire_pc),
        .retire_we      (retire_we),
        .retire_dest    (retire_dest),
        .retire_data    (retire_data),
        .retire_ex      (retire_ex),
        .retire_exccode (retire_exccode),
        .flush          (flush),
        .flush_target   (flush_target)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            cyc <= 32'd0;
        end else begin
            cyc <= cyc + 32'd1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_retire(input wb_bus_t got, input wb_bus_t exp);
        if (got.pc !== exp.pc)
            abort_run($sformatf("error retire_pc got %h exp %h", got.pc, exp.pc));
        if (got.we !== exp.we)
            abort_run($sformatf("error retire_we got %h exp %h pc %h", got.we, exp.we, exp.pc));
        if (got.dest !== exp.dest)
            abort_run($sformatf("error retire_dest got %h exp %h pc %h", got.dest, exp.dest,
                                exp.pc));
        if (got.data !== exp.data)
            abort_run($sformatf("error retire_data got %h exp %h pc %h", got.data, exp.data,
                                exp.pc));
    endtask

    // exception outcome of one retired op
    task automatic check_status(input op_e op, input wb_bus_t got, input wb_bus_t exp);
        if (got.ex !== exp.ex)
            abort_run($sformatf("error retire_ex got %h exp %h op %s pc %h", got.ex, exp.ex,
                                op.name(), exp.pc));
        if (got.exccode !== exp.exccode)
            abort_run($sformatf("error retire_exccode got %h exp %h op %s pc %h",
                                got.exccode, exp.exccode, op.name(), exp.pc));
    endtask

    task automatic check_flush(input logic [31:0] got_tgt, input logic got_flag,
                               input logic [31:0] exp_tgt, input logic exp_flag,
                               input logic [31:0] pc);
        if (got_flag !== exp_flag)
            abort_run($sformatf("error flush got %h exp %h pc %h", got_flag, exp_flag, pc));
        if (exp_flag && got_tgt !== exp_tgt)
            abort_run($sformatf("error flush_target got %h exp %h pc %h", got_tgt, exp_tgt, pc));
    endtask

    // mips cp0 read views, bev fixed at 1
    function automatic logic [31:0] read_cp0(input cp0_reg_e rd);
        logic [31:0] v;
        v = 32'd0;
        case (rd)
            cp0_status: begin
                v[status_bev] = 1'b1;
                v[15:8]       = m_im;
                v[1]          = m_exl;
                v[0]          = m_ie;
            end
            cp0_cause: begin
                v[31]   = m_bd;
                v[15:8] = {ext_int, m_ip_sw};  // hw lines stable while ops in flight
                v[6:2]  = m_code;
            end
            cp0_epc: v = m_epc;
            default: v = 32'd0;
        endcase
        return v;
    endfunction

    // expected retire fields and flush, then commit cp0 effects
    task automatic model_op(input ex_bus_t ib, output wb_bus_t exp,
                            output logic exp_flush, output logic [31:0] exp_tgt);
        logic [32:0] wide;
        logic [31:0] res;
        logic        ovf;
        logic        alu;
        logic        int_req;
        logic        fin_ex;
        exc_e        code;
        res = 32'd0;
        ovf = 1'b0;
        alu = 1'b1;
        case (ib.op)
            op_add: begin
                wide = {ib.src_a[31], ib.src_a} + {ib.src_b[31], ib.src_b};
                res  = wide[31:0];
                ovf  = wide[32] ^ wide[31];  // sign extension broken
            end
            op_sub: begin
                wide = {ib.src_a[31], ib.src_a} - {ib.src_b[31], ib.src_b};
                res  = wide[31:0];
                ovf  = wide[32] ^ wide[31];
            end
            op_and:  res = ib.src_a & ib.src_b;
            op_or:   res = ib.src_a | ib.src_b;
            op_xor:  res = ib.src_a ^ ib.src_b;
            op_slt:  res = ($signed(ib.src_a) < $signed(ib.src_b)) ? 32'd1 : 32'd0;
            op_mtc0: begin
                res = ib.src_a;
                alu = 1'b0;
            end
            op_mfc0: begin
                res = read_cp0(ib.cp0_rd);  // value before this op commits
                alu = 1'b0;
            end
            default: alu = 1'b0;
        endcase
        int_req = m_ie && !m_exl && (({ext_int, m_ip_sw} & m_im) != 8'd0);
        fin_ex  = ovf || (ib.op == op_syscall) || int_req;
        if (int_req) code = exc_int;
        else if (ib.op == op_syscall) code = exc_sys;
        else if (ovf) code = exc_ov;
        else code = exc_int;
        exp.pc      = ib.pc;
        exp.we      = (alu || ib.op == op_mfc0) && !fin_ex;
        exp.dest    = ib.dest;
        exp.data    = res;
        exp.ex      = fin_ex;
        exp.exccode = code;
        exp_flush   = fin_ex || (ib.op == op_eret);
        exp_tgt     = fin_ex ? exc_vector : m_epc;
        if (fin_ex) begin
            m_exl  = 1'b1;
            m_bd   = ib.bd;
            m_code = code;
            m_epc  = ib.bd ? ib.pc - 32'd4 : ib.pc;  // back to the branch
        end else if (ib.op == op_eret) begin
            m_exl = 1'b0;
        end else if (ib.op == op_mtc0) begin
            case (ib.cp0_rd)
                cp0_status: begin
                    m_im  = ib.src_a[15:8];
                    m_exl = ib.src_a[1];
                    m_ie  = ib.src_a[0];
                end
                cp0_cause: m_ip_sw = ib.src_a[9:8];
                default:   m_epc   = ib.src_a;
            endcase
        end
    endtask

    task automatic retire_one();
        entry_t      e;
        wb_bus_t     got;
        wb_bus_t     exp;
        logic        exp_flush;
        logic [31:0] exp_tgt;
        if (q.size() == 0) abort_run("an op retired with nothing in flight");
        e           = q.pop_front();
        got.pc      = retire_pc;
        got.we      = retire_we;
        got.dest    = retire_dest;
        got.data    = retire_data;
        got.ex      = retire_ex;
        got.exccode = retire_exccode;
        model_op(e.ib, exp, exp_flush, exp_tgt);
        check_retire(got, exp);
        check_status(e.ib.op, got, exp);
        check_flush(e.tgt, e.flushed, exp_tgt, exp_flush, e.ib.pc);
        // free flowing pipe gives fixed latency
        if (last_stall <= e.acc_cyc && cyc != e.acc_cyc + 32'd3)
            abort_run($sformatf("error retire cycle got %h exp %h pc %h", cyc,
                                e.acc_cyc + 32'd3, e.ib.pc));
        n_retired++;
    endtask

    // monitor, mid cycle where everything is settled
    always @(negedge clk) begin
        entry_t e;
        if (reset) begin
            m_im    = 8'd0;
            m_exl   = 1'b0;
            m_ie    = 1'b0;
            m_bd    = 1'b0;
            m_ip_sw = 2'd0;
            m_code  = exc_int;
            m_epc   = 32'd0;
        end else begin
            if (!retire_allowin) last_stall = cyc;
            if (retire_valid && retire_allowin) retire_one();
            if (flush) begin
                // issue side held off while redirecting
                if (issue_allowin !== 1'b0)
                    abort_run($sformatf("error issue_allowin got %h exp %h during flush",
                                        issue_allowin, 1'b0));
                // older ops gone, front is the op leaving m1
                if (q.size() == 0) abort_run("flush raised with nothing in flight");
                e         = q[0];
                e.flushed = 1'b1;
                e.tgt     = flush_target;
                q[0]      = e;
                while (q.size() > 1) begin
                    q.delete(q.size() - 1);
                    n_dropped++;
                end
            end
            if (issue_valid && issue_allowin) begin
                e.ib.op     = issue_op;
                e.ib.pc     = issue_pc;
                e.ib.src_a  = issue_src_a;
                e.ib.src_b  = issue_src_b;
                e.ib.dest   = issue_dest;
                e.ib.cp0_rd = issue_cp0_rd;
                e.ib.bd     = issue_bd;
                e.acc_cyc   = cyc;
                e.flushed   = 1'b0;
                e.tgt       = 32'd0;
                q.push_back(e);
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (stall_mode) retire_allowin = ($urandom_range(3) != 0);  // 1 in 4 stalls
        else retire_allowin = 1'b1;
    endtask

    task automatic make_op(input logic [31:0] pc, output ex_bus_t ib);
        int unsigned r;
        int unsigned k;
        r         = $urandom_range(99);
        k         = $urandom_range(2);
        ib.pc     = pc;
        ib.src_a  = $urandom();
        ib.src_b  = $urandom();
        ib.dest   = 5'($urandom_range(31));
        ib.bd     = ($urandom_range(3) == 0);
        ib.cp0_rd = (k == 0) ? cp0_status : ((k == 1) ? cp0_cause : cp0_epc);
        if (r < 55) ib.op = op_e'(4'($urandom_range(5)));  // alu ops
        else if (r < 70) ib.op = op_mtc0;
        else if (r < 85) ib.op = op_mfc0;
        else if (r < 93) ib.op = op_syscall;
        else ib.op = op_eret;
    endtask

    // hold the op until the handshake
    task automatic send_op(input ex_bus_t ib);
        logic taken;
        issue_valid  = 1'b1;
        issue_op     = ib.op;
        issue_pc     = ib.pc;
        issue_src_a  = ib.src_a;
        issue_src_b  = ib.src_b;
        issue_dest   = ib.dest;
        issue_cp0_rd = ib.cp0_rd;
        issue_bd     = ib.bd;
        taken        = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = issue_allowin;
            next_cycle();
        end
        issue_valid = 1'b0;
    endtask

    // interrupt lines move only with the pipe drained and idle
    task automatic change_int();
        while (q.size() != 0) next_cycle();
        repeat (4) next_cycle();
        if ($urandom_range(1) == 0) ext_int = 6'd0;
        else ext_int = 6'd1 << $urandom_range(5);
        repeat (2) next_cycle();
    endtask

    initial begin
        ex_bus_t     ib;
        logic [31:0] pc;
        void'($urandom(38990));
        reset          = 1'b1;
        ext_int        = 6'd0;
        issue_valid    = 1'b0;
        issue_op       = op_add;
        issue_pc       = 32'd0;
        issue_src_a    = 32'd0;
        issue_src_b    = 32'd0;
        issue_dest     = 5'd0;
        issue_cp0_rd   = cp0_status;
        issue_bd       = 1'b0;
        retire_allowin = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        pc    = 32'h0040_0000;
        for (int n = 0; n < n_ops; n++) begin
            stall_mode = ((n / 250) % 2 == 1);  // alternate free and stalled phases
            if ($urandom_range(63) == 0) change_int();
            make_op(pc, ib);
            send_op(ib);
            pc = pc + 32'd4;
            if ($urandom_range(2) == 0) repeat ($urandom_range(3, 1)) next_cycle();
        end
        while (q.size() != 0) next_cycle();
        repeat (4) next_cycle();
        if (q.size() == 0 && !retire_valid) begin
            $display("retired %0d ops, %0d dropped by flush", n_retired, n_dropped);
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("ops still in flight after the final drain");
        end
    end

    initial begin
        #(watchdog_time);
        abort_run("watchdog expired before all ops retired");
    end

endmodule

//--- vlog.f
cpu_isa_pkg.sv
pipe_pkg.sv
stage_if.sv
ex_stage.sv
cp0_regs.sv
m1_stage.sv
wb_stage.sv
backend_top.sv
tb_backend.sv

//--- run.sh
#!/bin/sh
# build and run the backend testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_backend -o tb_backend_sim

# nonzero exit on $fatal fails the script
./obj_dir/tb_backend_sim
